// File: common/col_pkg.sv
package col_pkg;

  // Width of the column field in row format, as it arrives from the user
  localparam int row_width = 16;

  // Real column width of the target DRAM, at most 12
  localparam int col_width = 10;

  localparam int buf_addr_width = 5;

  // Command queue payload. rd_wr is 1 for a read, size is 1 for two beats
  typedef struct packed {
    logic                      rd_wr;
    logic                      size;
    logic                      periodic;
    logic [buf_addr_width-1:0] buf_addr;
    logic [row_width-1:0]      col_a;
  } col_cmd_t;

  // One entry per read beat on the bus, consumed when the PHY returns data
  typedef struct packed {
    logic                      data_end;
    logic                      periodic;
    logic [buf_addr_width-1:0] buf_addr;
    logic                      offset;
  } rd_tag_t;

  // Drop A10/AP and A12/BC# from the row-format address, then trim to the
  // column width of the part
  function automatic logic [col_width-1:0] col_extract(input logic [row_width-1:0] col_a);
    logic [11:0] col_full;
    col_full = {col_a[13], col_a[11], col_a[9:0]};
    return col_full[col_width-1:0];
  endfunction

endpackage

// File: verilog/item_fifo.sv
`timescale 1ns/1ps

module item_fifo #(
  parameter type item_t = logic,
  parameter int depth = 4,
  // Free slots needed before in_ready is offered
  parameter int headroom = 1
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  in_valid,
  output logic  in_ready,
  input  item_t in_item,
  output logic  out_valid,
  input  logic  out_ready,
  output item_t out_item,
  output logic  empty
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  item_t            mem [depth];
  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [cnt_w-1:0] count;
  logic             live;
  logic             push;
  logic             pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(depth - 1))
      return '0;
    return p + ptr_w'(1);
  endfunction

  // A push only needs a free slot. With headroom above one the writer has
  // already reserved the extra slots when it saw in_ready
  assign push      = in_valid && live && (count != cnt_w'(depth));
  assign pop       = out_valid && out_ready;
  assign in_ready  = live && (count <= cnt_w'(depth - headroom));
  assign out_valid = (count != '0);
  assign out_item  = mem[head];
  assign empty     = (count == '0);

  always_ff @(posedge clk) begin
    if (push)
      mem[tail] <= in_item;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      live  <= 1'b0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      live <= 1'b1;
      if (push)
        tail <= next_ptr(tail);
      if (pop)
        head <= next_ptr(head);
      if (push && !pop)
        count <= count + cnt_w'(1);
      else if (pop && !push)
        count <= count - cnt_w'(1);
    end
  end

endmodule

// File: verilog/col_decode.sv
`timescale 1ns/1ps

module col_decode (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                in_valid,
  output logic                                in_ready,
  input  col_pkg::col_cmd_t                   in_item,
  output logic                                dec_valid,
  input  logic                                dec_ready,
  output logic                                dec_rd_wr,
  output logic                                dec_two_beats,
  output logic                                dec_periodic,
  output logic [col_pkg::buf_addr_width-1:0]  dec_buf_addr,
  output logic [col_pkg::col_width-1:0]       dec_col
);

  logic full_r;
  logic load;

  // Refill when the stage is empty or its command leaves this cycle
  assign in_ready  = !full_r || dec_ready;
  assign load      = in_valid && in_ready;
  assign dec_valid = full_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_r <= 1'b0;
    end else if (load) begin
      full_r <= 1'b1;
    end else if (dec_ready) begin
      full_r <= 1'b0;
    end
  end

  // The decoded fields only change on a load, so they hold under a stall
  always_ff @(posedge clk) begin
    if (load) begin
      dec_rd_wr     <= in_item.rd_wr;
      dec_two_beats <= in_item.size;
      dec_periodic  <= in_item.periodic;
      dec_buf_addr  <= in_item.buf_addr;
      dec_col       <= col_pkg::col_extract(in_item.col_a);
    end
  end

endmodule

// File: verilog/col_sequencer.sv
`timescale 1ns/1ps

module col_sequencer (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                dec_valid,
  output logic                                dec_ready,
  input  logic                                dec_rd_wr,
  input  logic                                dec_two_beats,
  input  logic                                dec_periodic,
  input  logic [col_pkg::buf_addr_width-1:0]  dec_buf_addr,
  input  logic [col_pkg::col_width-1:0]       dec_col,
  output logic                                tag_valid,
  input  logic                                tag_ready,
  output col_pkg::rd_tag_t                    tag_item,
  output logic                                cas_valid,
  output logic                                cas_rd_wr,
  output logic [col_pkg::col_width-1:0]       cas_col,
  output logic                                wr_data_en,
  output logic [col_pkg::buf_addr_width-1:0]  wr_data_addr,
  output logic                                wr_data_offset
);

  // High during the second beat of a two-beat burst
  logic                               offset_r;
  logic                               take;
  logic                               beat_active;
  logic                               data_end;
  logic                               cur_rd_wr;
  logic                               cur_periodic;
  logic [col_pkg::buf_addr_width-1:0] cur_buf_addr;
  logic                               beat_rd_wr;
  logic                               beat_periodic;
  logic [col_pkg::buf_addr_width-1:0] beat_buf_addr;

  // The data bus is busy while offset_r is set. A read also needs the tag
  // queue to have room for both of its beats, which tag_ready guarantees
  assign dec_ready = !offset_r && (!dec_rd_wr || tag_ready);
  assign take      = dec_valid && dec_ready;

  assign cas_valid = take;
  assign cas_rd_wr = dec_rd_wr;
  assign cas_col   = dec_col;

  always_ff @(posedge clk) begin
    if (rst) begin
      offset_r <= 1'b0;
    end else begin
      offset_r <= take && dec_two_beats;
    end
  end

  // Keep the command around for its second beat
  always_ff @(posedge clk) begin
    if (take) begin
      cur_rd_wr    <= dec_rd_wr;
      cur_periodic <= dec_periodic;
      cur_buf_addr <= dec_buf_addr;
    end
  end

  // Beat zero comes straight from the decode stage, beat one from the copy
  assign beat_active   = take || offset_r;
  assign beat_rd_wr    = offset_r ? cur_rd_wr    : dec_rd_wr;
  assign beat_periodic = offset_r ? cur_periodic : dec_periodic;
  assign beat_buf_addr = offset_r ? cur_buf_addr : dec_buf_addr;

  // A one-beat burst ends at once, a two-beat burst ends on offset one
  assign data_end = offset_r || !dec_two_beats;

  assign wr_data_en     = beat_active && !beat_rd_wr;
  assign wr_data_addr   = beat_buf_addr;
  assign wr_data_offset = offset_r;

  assign tag_valid         = beat_active && beat_rd_wr;
  assign tag_item.data_end = data_end;
  assign tag_item.periodic = beat_periodic;
  assign tag_item.buf_addr = beat_buf_addr;
  assign tag_item.offset   = offset_r;

endmodule

// File: read_return/read_return.sv
`timescale 1ns/1ps

module read_return (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                phy_rddata_valid,
  input  logic                                tag_valid,
  output logic                                tag_ready,
  input  col_pkg::rd_tag_t                    tag_item,
  output logic                                rd_data_en,
  output logic [col_pkg::buf_addr_width-1:0]  rd_data_addr,
  output logic                                rd_data_offset,
  output logic                                rd_data_end
);

  logic pop;

  // Every returned beat consumes the oldest tag. The PHY cannot return a beat
  // that was never issued, so a tag is waiting whenever data comes back
  assign tag_ready = phy_rddata_valid;
  assign pop       = phy_rddata_valid && tag_valid;

  // Calibration reads still pop their tags but stay hidden from the user
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data_en <= 1'b0;
    end else begin
      rd_data_en <= pop && !tag_item.periodic;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      rd_data_addr   <= tag_item.buf_addr;
      rd_data_offset <= tag_item.offset;
      rd_data_end    <= tag_item.data_end;
    end
  end

endmodule

// File: verilog/col_path_top.sv
`timescale 1ns/1ps

module col_path_top #(
  parameter int cmd_depth = 4,
  parameter int tag_depth = 8
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                cmd_valid,
  output logic                                cmd_ready,
  input  logic                                cmd_rd_wr,
  input  logic                                cmd_size,
  input  logic                                cmd_periodic,
  input  logic [col_pkg::buf_addr_width-1:0]  cmd_buf_addr,
  input  logic [col_pkg::row_width-1:0]       cmd_col_a,
  output logic                                cas_valid,
  output logic                                cas_rd_wr,
  output logic [col_pkg::col_width-1:0]       cas_col,
  output logic                                wr_data_en,
  output logic [col_pkg::buf_addr_width-1:0]  wr_data_addr,
  output logic                                wr_data_offset,
  input  logic                                phy_rddata_valid,
  output logic                                rd_data_en,
  output logic [col_pkg::buf_addr_width-1:0]  rd_data_addr,
  output logic                                rd_data_offset,
  output logic                                rd_data_end,
  output logic                                read_fifo_empty
);

  col_pkg::col_cmd_t                  cmd_item;
  col_pkg::col_cmd_t                  cmd_q_item;
  logic                               cmd_q_valid;
  logic                               cmd_q_ready;
  logic                               dec_valid;
  logic                               dec_ready;
  logic                               dec_rd_wr;
  logic                               dec_two_beats;
  logic                               dec_periodic;
  logic [col_pkg::buf_addr_width-1:0] dec_buf_addr;
  logic [col_pkg::col_width-1:0]      dec_col;
  logic                               tag_push_valid;
  logic                               tag_push_ready;
  col_pkg::rd_tag_t                   tag_push_item;
  logic                               tag_pop_valid;
  logic                               tag_pop_ready;
  col_pkg::rd_tag_t                   tag_pop_item;

  assign cmd_item = '{rd_wr: cmd_rd_wr, size: cmd_size, periodic: cmd_periodic,
                      buf_addr: cmd_buf_addr, col_a: cmd_col_a};

  item_fifo #(.item_t(col_pkg::col_cmd_t), .depth(cmd_depth), .headroom(1)) cmd_q (
    .clk(clk), .rst(rst),
    .in_valid(cmd_valid), .in_ready(cmd_ready), .in_item(cmd_item),
    .out_valid(cmd_q_valid), .out_ready(cmd_q_ready), .out_item(cmd_q_item),
    .empty()
  );

  col_decode decode0 (
    .clk(clk), .rst(rst),
    .in_valid(cmd_q_valid), .in_ready(cmd_q_ready), .in_item(cmd_q_item),
    .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_rd_wr(dec_rd_wr),
    .dec_two_beats(dec_two_beats), .dec_periodic(dec_periodic),
    .dec_buf_addr(dec_buf_addr), .dec_col(dec_col)
  );

  col_sequencer seq0 (
    .clk(clk), .rst(rst),
    .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_rd_wr(dec_rd_wr),
    .dec_two_beats(dec_two_beats), .dec_periodic(dec_periodic),
    .dec_buf_addr(dec_buf_addr), .dec_col(dec_col),
    .tag_valid(tag_push_valid), .tag_ready(tag_push_ready), .tag_item(tag_push_item),
    .cas_valid(cas_valid), .cas_rd_wr(cas_rd_wr), .cas_col(cas_col),
    .wr_data_en(wr_data_en), .wr_data_addr(wr_data_addr), .wr_data_offset(wr_data_offset)
  );

  // Two free slots are kept so a two-beat read never stalls mid-burst
  item_fifo #(.item_t(col_pkg::rd_tag_t), .depth(tag_depth), .headroom(2)) tag_q (
    .clk(clk), .rst(rst),
    .in_valid(tag_push_valid), .in_ready(tag_push_ready), .in_item(tag_push_item),
    .out_valid(tag_pop_valid), .out_ready(tag_pop_ready), .out_item(tag_pop_item),
    .empty(read_fifo_empty)
  );

  read_return ret0 (
    .clk(clk), .rst(rst),
    .phy_rddata_valid(phy_rddata_valid),
    .tag_valid(tag_pop_valid), .tag_ready(tag_pop_ready), .tag_item(tag_pop_item),
    .rd_data_en(rd_data_en), .rd_data_addr(rd_data_addr),
    .rd_data_offset(rd_data_offset), .rd_data_end(rd_data_end)
  );

endmodule

// File: bench/col_path_props.sv
`timescale 1ns/1ps

module col_path_props #(
  parameter int tag_depth = 8
) (
  input logic clk,
  input logic rst,
  input logic cas_valid,
  input logic dec_two_beats,
  input logic phy_rddata_valid,
  input logic rd_data_en,
  input logic tag_push_valid,
  input logic read_fifo_empty
);

  // Tag queue occupancy, tracked from the pushes and the pops at its ports
  int tag_level;

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_level <= 0;
    end else begin
      tag_level <= tag_level + int'(tag_push_valid)
                   - int'(phy_rddata_valid && !read_fifo_empty);
    end
  end

  // A two-beat burst keeps the data bus for the following cycle
  two_beat_gap: assert property (@(posedge clk) disable iff (rst)
    cas_valid && dec_two_beats |=> !cas_valid)
    else $error("column strobe issued while a two-beat burst held the bus");

  rd_en_after_phy: assert property (@(posedge clk) disable iff (rst)
    rd_data_en |-> $past(phy_rddata_valid))
    else $error("rd_data_en raised without a returned PHY beat");

  // Every read beat must find a free slot, the second one included
  tag_push_room: assert property (@(posedge clk) disable iff (rst)
    tag_push_valid |-> tag_level < tag_depth)
    else $error("read tag pushed into a full tag queue");

endmodule

bind col_path_top col_path_props #(.tag_depth(tag_depth)) props0 (
  .clk(clk),
  .rst(rst),
  .cas_valid(cas_valid),
  .dec_two_beats(dec_two_beats),
  .phy_rddata_valid(phy_rddata_valid),
  .rd_data_en(rd_data_en),
  .tag_push_valid(tag_push_valid),
  .read_fifo_empty(read_fifo_empty)
);

// File: bench/col_path_tb.sv
`timescale 1ns/1ps

module col_path_tb;

  localparam int max_pat = 32;
  // The first commands go one at a time, the rest as one burst
  localparam int paced_count = 8;
  localparam int wait_limit = 2000;

  logic                               clk = 1'b0;
  logic                               rst;
  logic                               cmd_valid;
  logic                               cmd_ready;
  logic                               cmd_rd_wr;
  logic                               cmd_size;
  logic                               cmd_periodic;
  logic [col_pkg::buf_addr_width-1:0] cmd_buf_addr;
  logic [col_pkg::row_width-1:0]      cmd_col_a;
  logic                               cas_valid;
  logic                               cas_rd_wr;
  logic [col_pkg::col_width-1:0]      cas_col;
  logic                               wr_data_en;
  logic [col_pkg::buf_addr_width-1:0] wr_data_addr;
  logic                               wr_data_offset;
  logic                               phy_rddata_valid = 1'b0;
  logic                               rd_data_en;
  logic [col_pkg::buf_addr_width-1:0] rd_data_addr;
  logic                               rd_data_offset;
  logic                               rd_data_end;
  logic                               read_fifo_empty;

  logic [15:0]                        pat_mem [6*max_pat];
  int                                 n_pat = 0;
  int                                 cas_count = 0;
  int                                 beats_issued = 0;
  int                                 beats_returned = 0;
  int                                 phy_wait = 0;
  int                                 seed = 37;
  int                                 check_count = 0;
  int                                 error_count = 0;
  logic                               wr_second = 1'b0;
  logic [col_pkg::buf_addr_width-1:0] wr_second_addr = '0;
  logic                               rd_due = 1'b0;
  col_pkg::rd_tag_t                   rd_exp_q[$];

  always #2 clk = ~clk;

  col_path_top dut0 (.*);

  function automatic col_pkg::col_cmd_t pat_cmd(input int i);
    col_pkg::col_cmd_t c;
    c.rd_wr    = pat_mem[6*i][0];
    c.size     = pat_mem[6*i+1][0];
    c.periodic = pat_mem[6*i+2][0];
    c.buf_addr = pat_mem[6*i+3][col_pkg::buf_addr_width-1:0];
    c.col_a    = pat_mem[6*i+4];
    return c;
  endfunction

  function automatic logic [col_pkg::col_width-1:0] pat_col(input int i);
    return pat_mem[6*i+5][col_pkg::col_width-1:0];
  endfunction

  function automatic bit drained();
    return cas_count >= n_pat && beats_returned == beats_issued &&
           rd_exp_q.size() == 0 && !rd_due;
  endfunction

  task automatic report_error(input string what);
    error_count++;
    $display("[ERROR] %0t: %s", $time, what);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    $display("Checks failed");
    $finish;
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
      report_error($sformatf("%s is %b, expected %b", name, got, exp));
  endtask

  task automatic check_cas(input int idx, input logic exp_rd_wr,
                           input logic [col_pkg::col_width-1:0] exp_col);
    check_count++;
    if (cas_rd_wr !== exp_rd_wr || cas_col !== exp_col)
      report_error($sformatf("command %0d strobe rd_wr %b col %h, expected rd_wr %b col %h",
                             idx, cas_rd_wr, cas_col, exp_rd_wr, exp_col));
  endtask

  task automatic check_write_beat(input logic exp_en,
                                  input logic [col_pkg::buf_addr_width-1:0] exp_addr,
                                  input logic exp_offset);
    check_count++;
    if (wr_data_en !== exp_en)
      report_error($sformatf("wr_data_en is %b, expected %b", wr_data_en, exp_en));
    else if (exp_en && (wr_data_addr !== exp_addr || wr_data_offset !== exp_offset))
      report_error($sformatf("write beat addr %h offset %b, expected addr %h offset %b",
                             wr_data_addr, wr_data_offset, exp_addr, exp_offset));
  endtask

  task automatic check_read_beat(input logic exp_en, input col_pkg::rd_tag_t exp);
    check_count++;
    if (rd_data_en !== exp_en)
      report_error($sformatf("rd_data_en is %b, expected %b", rd_data_en, exp_en));
    else if (exp_en && (rd_data_addr !== exp.buf_addr || rd_data_offset !== exp.offset ||
                        rd_data_end !== exp.data_end))
      report_error($sformatf("read beat addr %h offset %b end %b, expected %h %b %b",
                             rd_data_addr, rd_data_offset, rd_data_end,
                             exp.buf_addr, exp.offset, exp.data_end));
  endtask

  // Present one command and hold it until the queue shows cmd_ready
  task automatic send_cmd(input int i);
    col_pkg::col_cmd_t c;
    int                n;
    c = pat_cmd(i);
    n = 0;
    @(posedge clk);
    cmd_valid    <= 1'b1;
    cmd_rd_wr    <= c.rd_wr;
    cmd_size     <= c.size;
    cmd_periodic <= c.periodic;
    cmd_buf_addr <= c.buf_addr;
    cmd_col_a    <= c.col_a;
    do begin
      @(negedge clk);
      n++;
    end while (cmd_ready !== 1'b1 && n < wait_limit);
    if (cmd_ready !== 1'b1)
      abort_run($sformatf("Timeout: command %0d was never accepted", i));
  endtask

  task automatic wait_cas_count(input int target);
    int n;
    n = 0;
    while (cas_count < target && n < wait_limit) begin
      @(posedge clk);
      n++;
    end
    if (cas_count < target)
      abort_run($sformatf("Timeout: column strobe %0d never appeared", target - 1));
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (!drained() && n < wait_limit) begin
      @(posedge clk);
      n++;
    end
    if (!drained())
      abort_run("Timeout: commands or read data were still outstanding");
  endtask

  // PHY model, returning one issued read beat after a random gap
  always @(posedge clk) begin
    if (rst) begin
      phy_rddata_valid <= 1'b0;
      phy_wait         <= 0;
    end else if (phy_wait != 0) begin
      phy_rddata_valid <= 1'b0;
      phy_wait         <= phy_wait - 1;
    end else if (beats_returned != beats_issued) begin
      phy_rddata_valid <= 1'b1;
      beats_returned   <= beats_returned + 1;
      phy_wait         <= int'($unsigned($random(seed)) % 6);
    end else begin
      phy_rddata_valid <= 1'b0;
    end
  end

  // Monitor for strobes, write beats and read beats
  always @(negedge clk) begin
    col_pkg::col_cmd_t                  c;
    col_pkg::rd_tag_t                   t;
    logic                               exp_wr_en;
    logic [col_pkg::buf_addr_width-1:0] exp_wr_addr;
    logic                               exp_wr_off;
    if (!rst) begin
      exp_wr_en   = wr_second;
      exp_wr_addr = wr_second_addr;
      exp_wr_off  = wr_second;
      wr_second   = 1'b0;
      if (cas_valid === 1'b1) begin
        if (cas_count >= n_pat) begin
          error_count++;
          $display("A column strobe appeared after the last command had been issued");
        end else begin
          c = pat_cmd(cas_count);
          check_cas(cas_count, c.rd_wr, pat_col(cas_count));
          if (!c.rd_wr) begin
            exp_wr_en      = 1'b1;
            exp_wr_addr    = c.buf_addr;
            exp_wr_off     = 1'b0;
            wr_second      = c.size;
            wr_second_addr = c.buf_addr;
          end else begin
            t.buf_addr = c.buf_addr;
            t.periodic = c.periodic;
            t.offset   = 1'b0;
            t.data_end = !c.size;
            rd_exp_q.push_back(t);
            if (c.size) begin
              t.offset   = 1'b1;
              t.data_end = 1'b1;
              rd_exp_q.push_back(t);
            end
            beats_issued = beats_issued + (c.size ? 2 : 1);
          end
        end
        cas_count++;
      end
      check_write_beat(exp_wr_en, exp_wr_addr, exp_wr_off);
      // A PHY pulse seen last cycle owes a registered read beat now
      if (rd_due && rd_exp_q.size() == 0) begin
        error_count++;
        $display("Read data came back with no read beat outstanding");
      end else if (rd_due) begin
        t = rd_exp_q.pop_front();
        check_read_beat(!t.periodic, t);
      end else begin
        check_read_beat(1'b0, '0);
      end
      rd_due = phy_rddata_valid;
    end
  end

  initial begin
    rst          = 1'b1;
    cmd_valid    = 1'b0;
    cmd_rd_wr    = 1'b0;
    cmd_size     = 1'b0;
    cmd_periodic = 1'b0;
    cmd_buf_addr = '0;
    cmd_col_a    = '0;
    for (int k = 0; k < 6*max_pat; k++)
      pat_mem[k] = 16'hf000 | 16'(k);
    $readmemh("bench/col_patterns.txt", pat_mem);
    while (n_pat < max_pat && pat_mem[6*n_pat] <= 16'h1)
      n_pat++;
    if (n_pat == 0)
      abort_run("No commands could be read from bench/col_patterns.txt");
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_flag("cmd_ready in reset", cmd_ready, 1'b0);
    check_flag("read_fifo_empty in reset", read_fifo_empty, 1'b1);
    check_flag("cas_valid in reset", cas_valid, 1'b0);
    check_flag("wr_data_en in reset", wr_data_en, 1'b0);
    check_flag("rd_data_en in reset", rd_data_en, 1'b0);
    @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_pat; i++) begin
      send_cmd(i);
      if (i < paced_count) begin
        @(posedge clk);
        cmd_valid <= 1'b0;
        wait_cas_count(i + 1);
      end
    end
    @(posedge clk);
    cmd_valid <= 1'b0;
    wait_drain();
    repeat (4) @(negedge clk);
    check_flag("read_fifo_empty at the end", read_fifo_empty, 1'b1);
    if (cas_count != n_pat) begin
      error_count++;
      $display("Saw %0d column strobes for %0d commands", cas_count, n_pat);
    end
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: bench/col_patterns.txt
// rd_wr size periodic buf_addr col_a expected_col, all hex, one command per line
// rd_wr 1 is a read, size 1 is two beats, periodic 1 is a calibration read
0 0 0 01 0008 008
0 1 0 02 1410 010
1 0 0 03 0020 020
1 1 0 04 2C48 048
1 1 1 05 0100 100
1 0 0 06 07F8 3F8
1 0 1 07 0200 200
0 1 0 08 3FFF 3FF
1 1 0 09 0040 040
1 1 0 0A 0048 048
1 1 0 0B 1450 050
1 1 1 0C 0058 058
1 1 0 0D 0060 060
0 1 0 0E 0068 068
1 1 0 0F 0470 070
1 0 0 10 0078 078
1 1 0 1F 0380 380
1 1 0 11 2388 388

// File: tb.f
common/col_pkg.sv
verilog/item_fifo.sv
verilog/col_decode.sv
verilog/col_sequencer.sv
read_return/read_return.sv
verilog/col_path_top.sv
bench/col_path_props.sv
bench/col_path_tb.sv

// File: Makefile
# Verilator flow for the column path testbench

VERILATOR ?= verilator
TOP       ?= col_path_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=
PASS_MSG  ?= All checks passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass message shows up as a line of its own
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
